/* hdl/main_reg_pkg.sv */
// Shared definitions for the main register block.
// The register window is 64 addresses wide, picked by address bits 7:6.
// FIFO words are 18 bits; the stream-empty marker uses the low 10 bits only.

package main_reg_pkg;

   ////////////////////////////////////////
   // Bus window and field widths
   ////////////////////////////////////////

   localparam logic [1:0] main_sel = 2'd0;
   localparam int bytecnt_w = 7;
   localparam int capture_len_w = 24;
   localparam int capture_len_bytes = capture_len_w / 8;
   localparam int fifo_w = 18;
   localparam int fifo_status_w = 6;
   localparam int fe_sel_w = 2;

   // Register addresses inside the window, anything else is unmapped
   typedef enum logic [5:0] {
      FE_SELECT          = 6'd1,
      ARM                = 6'd2,
      CAPTURE_LEN        = 6'd3,
      COUNT_WRITES       = 6'd4,
      CAPTURE_WHILE_TRIG = 6'd5,
      FIFO_STAT          = 6'd6,
      FIFO_RD            = 6'd7
   } reg_addr_e;

   // Front-end selection
   typedef enum logic [fe_sel_w-1:0] {
      FE_USB   = 2'd0,
      FE_TRACE = 2'd1,
      FE_ALT   = 2'd2
   } fe_sel_e;

   ////////////////////////////////////////
   // Reset values
   ////////////////////////////////////////

   localparam fe_sel_e fe_select_rst = FE_USB;
   localparam logic [capture_len_w-1:0] capture_len_rst = '0;
   localparam logic count_writes_rst = 1'b0;
   localparam logic capture_while_trig_rst = 1'b0;

   ////////////////////////////////////////
   // FIFO word layout
   ////////////////////////////////////////

   // Top two data bits go out with the status in the last byte of a group
   localparam int fifo_hi_lsb = 16;

   // Stream-empty marker fields
   localparam int fifo_cmd_lsb = 0;
   localparam int fifo_cmd_w = 2;
   localparam int fifo_data_lsb = 2;
   localparam int fifo_data_w = 8;
   localparam logic [fifo_cmd_w-1:0] fifo_cmd_strm = 2'b11;
   localparam logic [fifo_data_w-1:0] fifo_strm_empty = 8'hEE;

endpackage

/* hdl/reg_decode.sv */
// Register bus decode for the main block window.
// Everything here is combinational apart from one flop on reg_read,
// so rd_first relies on reg_read dropping between separate reads.

`timescale 1ns/100ps

module reg_decode import main_reg_pkg::*; (
   input  logic                 cwusb_clk,
   input  logic                 fpga_reset,
   input  logic [7:0]           reg_address,
   input  logic [bytecnt_w-1:0] reg_bytecnt,
   input  logic                 reg_read,
   input  logic                 reg_write,
   input  logic                 reg_addrvalid,
   output logic                 selected,
   output logic                 wr_en,
   output logic                 rd_en,
   output logic                 rd_first,
   output reg_addr_e            addr,
   output logic [bytecnt_w-1:0] byte_idx,
   output logic                 arm_write,
   output logic                 fifo_group_start
);

   logic reg_read_r;

   // Previous read strobe, for first-cycle detection
   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         reg_read_r <= 1'b0;
      end else begin
         reg_read_r <= reg_read;
      end
   end

   assign selected = reg_addrvalid && (reg_address[7:6] == main_sel);
   assign addr     = reg_addr_e'(reg_address[5:0]);
   assign byte_idx = reg_bytecnt;

   assign wr_en    = selected && reg_write;
   assign rd_en    = selected && reg_read;
   assign rd_first = rd_en && !reg_read_r;

   // ARM is handled apart from the plain config registers
   assign arm_write = wr_en && (addr == ARM);

   // Start of a four-byte FIFO group
   assign fifo_group_start = rd_first && (addr == FIFO_RD) && (reg_bytecnt[1:0] == 2'd0);

endmodule

/* hdl/config_regs.sv */
// Writable configuration registers of the main block and their readback.
// CAPTURE_LEN is written one byte per byte count; counts past the top byte
// are ignored on write and read back as 0. FIFO_RD readback lives elsewhere.

`timescale 1ns/100ps

module config_regs import main_reg_pkg::*; (
   input  logic                     cwusb_clk,
   input  logic                     fpga_reset,
   input  logic                     wr_en,
   input  logic                     rd_en,
   input  reg_addr_e                addr,
   input  logic [bytecnt_w-1:0]     byte_idx,
   input  logic [7:0]               write_data,
   input  logic                     reg_arm,
   input  logic [fifo_status_w-1:0] fifo_status,
   output fe_sel_e                  fe_select,
   output logic [capture_len_w-1:0] capture_len,
   output logic                     count_writes,
   output logic                     capture_while_trig,
   output logic [7:0]               cfg_rd_byte
);

   logic len_byte_ok;
   logic [7:0] len_rd_byte;

   // Byte count inside the capture length register
   assign len_byte_ok = (byte_idx < bytecnt_w'(capture_len_bytes));

   ////////////////////////////////////////
   // Write side
   ////////////////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         fe_select          <= fe_select_rst;
         capture_len        <= capture_len_rst;
         count_writes       <= count_writes_rst;
         capture_while_trig <= capture_while_trig_rst;
      end else if (wr_en) begin
         case (addr)
            FE_SELECT: begin
               fe_select <= fe_sel_e'(write_data[fe_sel_w-1:0]);
            end
            CAPTURE_LEN: begin
               if (len_byte_ok) begin
                  capture_len[byte_idx*8 +: 8] <= write_data;
               end
            end
            COUNT_WRITES: begin
               count_writes <= write_data[0];
            end
            CAPTURE_WHILE_TRIG: begin
               capture_while_trig <= write_data[0];
            end
            default: begin
               // ARM, status and unmapped addresses hold nothing here
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Readback
   ////////////////////////////////////////

   always_comb begin
      if (len_byte_ok) begin
         len_rd_byte = capture_len[byte_idx*8 +: 8];
      end else begin
         len_rd_byte = 8'd0;
      end
   end

   always_comb begin
      cfg_rd_byte = 8'd0;
      if (rd_en) begin
         case (addr)
            FE_SELECT: begin
               cfg_rd_byte = {{(8-fe_sel_w){1'b0}}, fe_select};
            end
            ARM: begin
               cfg_rd_byte = {7'd0, reg_arm};
            end
            CAPTURE_LEN: begin
               cfg_rd_byte = len_rd_byte;
            end
            COUNT_WRITES: begin
               cfg_rd_byte = {7'd0, count_writes};
            end
            CAPTURE_WHILE_TRIG: begin
               cfg_rd_byte = {7'd0, capture_while_trig};
            end
            FIFO_STAT: begin
               cfg_rd_byte = {{(8-fifo_status_w){1'b0}}, fifo_status};
            end
            default: begin
               cfg_rd_byte = 8'd0;
            end
         endcase
      end
   end

endmodule

/* hdl/capture_ctrl.sv */
// Arm and capture-now control for the capture front end.
// capture_started must already be a single-cycle pulse in cwusb_clk.
// A write that sets arm wins over a capture start in the same cycle.

`timescale 1ns/100ps

module capture_ctrl (
   input  logic       cwusb_clk,
   input  logic       fpga_reset,
   input  logic       arm_write,
   input  logic [7:0] write_data,
   input  logic       capture_started,
   input  logic       flushing,
   output logic       reg_arm,
   output logic       arm,
   output logic       arm_pulse,
   output logic       capture_now
);

   logic reg_arm_r;
   logic cap_req;
   logic cap_req_r;

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         reg_arm   <= 1'b0;
         reg_arm_r <= 1'b0;
         cap_req   <= 1'b0;
         cap_req_r <= 1'b0;
      end else begin
         reg_arm_r <= reg_arm;
         cap_req_r <= cap_req;

         // Arm request, held until the front end starts a capture
         if (arm_write && write_data[0]) begin
            reg_arm <= 1'b1;
         end else if (capture_started) begin
            reg_arm <= 1'b0;
         end

         cap_req <= arm_write && write_data[1];
      end
   end

   // First cycle of the arm request only
   assign arm_pulse = reg_arm && !reg_arm_r;

   // Follows the pulse, dropped while the front end flushes
   assign arm = reg_arm && reg_arm_r && !flushing;

   // Rising edge only, so back-to-back writes still give one cycle
   assign capture_now = cap_req && !cap_req_r;

endmodule

/* hdl/read_path.sv */
// FIFO read path and registered read data of the main block.
// The FIFO must be first-word-fall-through. One pop per four-byte group;
// byte 0 of each group reads 0 while the popped word is latched.
// The empty check uses fifo_empty as it was one cycle before the group start.

`timescale 1ns/100ps

module read_path import main_reg_pkg::*; (
   input  logic                     cwusb_clk,
   input  logic                     fpga_reset,
   input  logic                     rd_en,
   input  logic                     fifo_group_start,
   input  reg_addr_e                addr,
   input  logic [bytecnt_w-1:0]     byte_idx,
   input  logic [7:0]               cfg_rd_byte,
   input  logic [fifo_w-1:0]        fifo_data,
   input  logic [fifo_status_w-1:0] fifo_status,
   input  logic                     fifo_empty,
   output logic                     fifo_read,
   output logic [7:0]               read_data
);

   logic fifo_empty_r;
   logic empty_strm;
   logic [fifo_w-1:0] fifo_word;
   logic [fifo_w-1:0] marker_word;
   logic [fifo_w-1:0] src_word;
   logic [7:0] lane_byte;
   logic [7:0] rd_byte;

   ////////////////////////////////////////
   // FIFO pop and empty-stream tracking
   ////////////////////////////////////////

   assign fifo_read = fifo_group_start && !fifo_empty_r;

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         fifo_empty_r <= 1'b1;
         empty_strm   <= 1'b0;
      end else begin
         fifo_empty_r <= fifo_empty;
         if (fifo_group_start) begin
            empty_strm <= fifo_empty_r;
         end
      end
   end

   // Head word captured on the pop
   always_ff @(posedge cwusb_clk) begin
      if (fifo_read) begin
         fifo_word <= fifo_data;
      end
   end

   ////////////////////////////////////////
   // Byte lane select
   ////////////////////////////////////////

   always_comb begin
      marker_word = '0;
      marker_word[fifo_cmd_lsb +: fifo_cmd_w]   = fifo_cmd_strm;
      marker_word[fifo_data_lsb +: fifo_data_w] = fifo_strm_empty;
   end

   assign src_word = empty_strm ? marker_word : fifo_word;

   always_comb begin
      case (byte_idx[1:0])
         2'd1:    lane_byte = src_word[7:0];
         2'd2:    lane_byte = src_word[15:8];
         2'd3:    lane_byte = {fifo_status, src_word[fifo_w-1:fifo_hi_lsb]};
         default: lane_byte = 8'd0;
      endcase
   end

   // Config readback is already 0 outside a selected read
   always_comb begin
      if (rd_en && (addr == FIFO_RD)) begin
         rd_byte = lane_byte;
      end else begin
         rd_byte = cfg_rd_byte;
      end
   end

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         read_data <= 8'd0;
      end else begin
         read_data <= rd_byte;
      end
   end

endmodule

/* hdl/reg_main.sv */
// Main register block for the capture board, all in the cwusb_clk domain.
// Read data comes one cycle after the read strobe; there is no back-pressure.

`timescale 1ns/100ps

module reg_main import main_reg_pkg::*; (
   input  logic                     cwusb_clk,
   input  logic                     fpga_reset,
   // Register bus
   input  logic [7:0]               reg_address,
   input  logic [bytecnt_w-1:0]     reg_bytecnt,
   input  logic [7:0]               write_data,
   input  logic                     reg_read,
   input  logic                     reg_write,
   input  logic                     reg_addrvalid,
   output logic [7:0]               read_data,
   output logic                     selected,
   // Sniff FIFO
   input  logic [fifo_w-1:0]        fifo_data,
   input  logic [fifo_status_w-1:0] fifo_status,
   input  logic                     fifo_empty,
   output logic                     fifo_read,
   // Capture front end
   input  logic                     capture_started,
   input  logic                     flushing,
   output fe_sel_e                  fe_select,
   output logic [capture_len_w-1:0] capture_len,
   output logic                     count_writes,
   output logic                     capture_while_trig,
   output logic                     reg_arm,
   output logic                     arm,
   output logic                     arm_pulse,
   output logic                     capture_now
);

   logic wr_en;
   logic rd_en;
   logic arm_write;
   logic fifo_group_start;
   reg_addr_e addr;
   logic [bytecnt_w-1:0] byte_idx;
   logic [7:0] cfg_rd_byte;

   reg_decode u_decode (
      .cwusb_clk        (cwusb_clk),
      .fpga_reset       (fpga_reset),
      .reg_address      (reg_address),
      .reg_bytecnt      (reg_bytecnt),
      .reg_read         (reg_read),
      .reg_write        (reg_write),
      .reg_addrvalid    (reg_addrvalid),
      .selected         (selected),
      .wr_en            (wr_en),
      .rd_en            (rd_en),
      .rd_first         (),
      .addr             (addr),
      .byte_idx         (byte_idx),
      .arm_write        (arm_write),
      .fifo_group_start (fifo_group_start)
   );

   config_regs u_config (
      .cwusb_clk          (cwusb_clk),
      .fpga_reset         (fpga_reset),
      .wr_en              (wr_en),
      .rd_en              (rd_en),
      .addr               (addr),
      .byte_idx           (byte_idx),
      .write_data         (write_data),
      .reg_arm            (reg_arm),
      .fifo_status        (fifo_status),
      .fe_select          (fe_select),
      .capture_len        (capture_len),
      .count_writes       (count_writes),
      .capture_while_trig (capture_while_trig),
      .cfg_rd_byte        (cfg_rd_byte)
   );

   capture_ctrl u_capture (
      .cwusb_clk       (cwusb_clk),
      .fpga_reset      (fpga_reset),
      .arm_write       (arm_write),
      .write_data      (write_data),
      .capture_started (capture_started),
      .flushing        (flushing),
      .reg_arm         (reg_arm),
      .arm             (arm),
      .arm_pulse       (arm_pulse),
      .capture_now     (capture_now)
   );

   read_path u_read (
      .cwusb_clk        (cwusb_clk),
      .fpga_reset       (fpga_reset),
      .rd_en            (rd_en),
      .fifo_group_start (fifo_group_start),
      .addr             (addr),
      .byte_idx         (byte_idx),
      .cfg_rd_byte      (cfg_rd_byte),
      .fifo_data        (fifo_data),
      .fifo_status      (fifo_status),
      .fifo_empty       (fifo_empty),
      .fifo_read        (fifo_read),
      .read_data        (read_data)
   );

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock and reset source.
// 8 ns clock; fpga_reset is high for the first 3 rising edges.

`timescale 1ns/100ps

module tb_clock_gen (
   output logic cwusb_clk,
   output logic fpga_reset
);

   localparam real half_period = 4.0;
   localparam int reset_cycles = 3;

   initial begin
      cwusb_clk = 1'b0;
      forever #(half_period) cwusb_clk = ~cwusb_clk;
   end

   initial begin
      fpga_reset = 1'b1;
      repeat (reset_cycles) @(posedge cwusb_clk);
      fpga_reset <= 1'b0;
   end

endmodule

/* test/reg_main_sva.sv */
// Pulse and strobe properties of the read path and the capture control.
// One checker serves both targets; the inputs a target lacks are tied off.

`timescale 1ns/100ps

module reg_main_sva (
   input logic cwusb_clk,
   input logic fpga_reset,
   input logic fifo_read,
   input logic fifo_empty,
   input logic flushing,
   input logic arm,
   input logic arm_pulse,
   input logic capture_now
);

   fifo_read_single: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      fifo_read |=> !fifo_read)
      else $error("fifo_read high for more than one cycle");

   // Pop only when the FIFO showed data one cycle earlier
   fifo_read_not_empty: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      fifo_read |-> !$past(fifo_empty))
      else $error("fifo_read while the registered empty flag was set");

   arm_pulse_single: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      arm_pulse |=> !arm_pulse)
      else $error("arm_pulse high for more than one cycle");

   capture_now_single: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      capture_now |=> !capture_now)
      else $error("capture_now high for more than one cycle");

   arm_low_flushing: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      flushing |-> !arm)
      else $error("arm high while flushing");

endmodule

bind read_path reg_main_sva read_path_sva (
   .cwusb_clk    (cwusb_clk),
   .fpga_reset   (fpga_reset),
   .fifo_read    (fifo_read),
   .fifo_empty   (fifo_empty),
   .flushing     (1'b0),
   .arm          (1'b0),
   .arm_pulse    (1'b0),
   .capture_now  (1'b0)
);

bind capture_ctrl reg_main_sva capture_ctrl_sva (
   .cwusb_clk    (cwusb_clk),
   .fpga_reset   (fpga_reset),
   .fifo_read    (1'b0),
   .fifo_empty   (1'b0),
   .flushing     (flushing),
   .arm          (arm),
   .arm_pulse    (arm_pulse),
   .capture_now  (capture_now)
);

/* test/reg_main_tb.sv */
// Testbench for the main register block with a first-word-fall-through FIFO model.
// Bus inputs change on the falling edge; every read is checked by a compare process.
// Random data comes from $random with a fixed seed.

`timescale 1ns/100ps

module reg_main_tb import main_reg_pkg::*; ();

   logic cwusb_clk;
   logic fpga_reset;
   logic [7:0] reg_address;
   logic [bytecnt_w-1:0] reg_bytecnt;
   logic [7:0] write_data;
   logic reg_read;
   logic reg_write;
   logic reg_addrvalid;
   logic [7:0] read_data;
   logic selected;
   logic [fifo_w-1:0] fifo_data;
   logic [fifo_status_w-1:0] fifo_status;
   logic fifo_empty;
   logic fifo_read;
   logic capture_started;
   logic flushing;
   fe_sel_e fe_select;
   logic [capture_len_w-1:0] capture_len;
   logic count_writes;
   logic capture_while_trig;
   logic reg_arm;
   logic arm;
   logic arm_pulse;
   logic capture_now;

   // Model register state
   fe_sel_e m_fe;
   logic [capture_len_w-1:0] m_len;
   logic m_cw;
   logic m_cwt;
   logic m_arm;
   logic [fifo_w-1:0] m_word;
   logic m_empty;

   // Model FIFO and pulse counters
   logic [fifo_w-1:0] fifo_q[$];
   logic pop_seen = 1'b0;
   int fifo_read_cnt = 0;
   int arm_pulse_cnt = 0;
   int capture_now_cnt = 0;

   // Compare process state
   logic cmp_armed = 1'b0;
   logic [7:0] cmp_exp;
   logic [7:0] cmp_addr;
   logic [bytecnt_w-1:0] cmp_bc;

   integer seed = 52;
   int errors = 0;
   int checks = 0;
   int tests = 0;
   int err_mark = 0;
   int i;
   int kind;
   int timeout;
   int count_before;
   logic valid;
   logic [7:0] address;
   logic [7:0] data;
   logic [bytecnt_w-1:0] bc;

   tb_clock_gen clock_gen (
      .cwusb_clk  (cwusb_clk),
      .fpga_reset (fpga_reset)
   );

   reg_main UUT (
      .cwusb_clk          (cwusb_clk),
      .fpga_reset         (fpga_reset),
      .reg_address        (reg_address),
      .reg_bytecnt        (reg_bytecnt),
      .write_data         (write_data),
      .reg_read           (reg_read),
      .reg_write          (reg_write),
      .reg_addrvalid      (reg_addrvalid),
      .read_data          (read_data),
      .selected           (selected),
      .fifo_data          (fifo_data),
      .fifo_status        (fifo_status),
      .fifo_empty         (fifo_empty),
      .fifo_read          (fifo_read),
      .capture_started    (capture_started),
      .flushing           (flushing),
      .fe_select          (fe_select),
      .capture_len        (capture_len),
      .count_writes       (count_writes),
      .capture_while_trig (capture_while_trig),
      .reg_arm            (reg_arm),
      .arm                (arm),
      .arm_pulse          (arm_pulse),
      .capture_now        (capture_now)
   );

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   function automatic logic [7:0] ref_byte(input logic vld, input logic [7:0] adr,
                                           input logic [bytecnt_w-1:0] cnt);
      logic [fifo_w-1:0] word;
      logic [7:0] result;
      result = 8'd0;
      word = '0;
      if (vld && (adr[7:6] == main_sel)) begin
         case (reg_addr_e'(adr[5:0]))
            FE_SELECT:          result = {6'd0, m_fe};
            ARM:                result = {7'd0, m_arm};
            COUNT_WRITES:       result = {7'd0, m_cw};
            CAPTURE_WHILE_TRIG: result = {7'd0, m_cwt};
            FIFO_STAT:          result = {2'd0, fifo_status};
            CAPTURE_LEN: begin
               if (cnt < capture_len_w / 8) begin
                  result = m_len[cnt*8 +: 8];
               end
            end
            FIFO_RD: begin
               // Marker word when the last group found the FIFO empty
               if (m_empty) begin
                  word[1:0] = fifo_cmd_strm;
                  word[9:2] = fifo_strm_empty;
               end else begin
                  word = m_word;
               end
               case (cnt[1:0])
                  2'd1:    result = word[7:0];
                  2'd2:    result = word[15:8];
                  2'd3:    result = {fifo_status, word[17:16]};
                  default: result = 8'd0;
               endcase
            end
            default: result = 8'd0;
         endcase
      end
      return result;
   endfunction

   task automatic model_write(input logic vld, input logic [7:0] adr,
                              input logic [bytecnt_w-1:0] cnt, input logic [7:0] dat);
      if (vld && (adr[7:6] == main_sel)) begin
         case (reg_addr_e'(adr[5:0]))
            FE_SELECT:          m_fe = fe_sel_e'(dat[1:0]);
            COUNT_WRITES:       m_cw = dat[0];
            CAPTURE_WHILE_TRIG: m_cwt = dat[0];
            ARM: begin
               if (dat[0]) begin
                  m_arm = 1'b1;
               end
            end
            CAPTURE_LEN: begin
               if (cnt < capture_len_w / 8) begin
                  m_len[cnt*8 +: 8] = dat;
               end
            end
            default: begin
            end
         endcase
      end
   endtask

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s got %02h, expected %02h", $time, what, got, exp);
      end
   endtask

   task automatic check_fe(input fe_sel_e got, input fe_sel_e exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s got %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_len(input logic [capture_len_w-1:0] got,
                            input logic [capture_len_w-1:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s got %06h, expected %06h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s got %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      checks++;
      if (got != exp) begin
         errors++;
         $display("[ERROR] %0t: %s got %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_config();
      check_fe(fe_select, m_fe, "fe_select");
      check_len(capture_len, m_len, "capture_len");
      check_bit(count_writes, m_cw, "count_writes");
      check_bit(capture_while_trig, m_cwt, "capture_while_trig");
   endtask

   // Every read is compared one cycle after its strobe
   always @(posedge cwusb_clk) begin
      cmp_armed <= reg_read && !fpga_reset;
      cmp_exp   <= ref_byte(reg_addrvalid, reg_address, reg_bytecnt);
      cmp_addr  <= reg_address;
      cmp_bc    <= reg_bytecnt;
   end

   always @(negedge cwusb_clk) begin
      if (cmp_armed) begin
         check_byte(read_data, cmp_exp, $sformatf("read_data of %02h/%0d", cmp_addr, cmp_bc));
      end
   end

   ////////////////////////////////////////
   // FIFO model and pulse counters
   ////////////////////////////////////////

   always @(posedge cwusb_clk) begin
      pop_seen <= fifo_read;
      if (fifo_read) fifo_read_cnt <= fifo_read_cnt + 1;
      if (arm_pulse) arm_pulse_cnt <= arm_pulse_cnt + 1;
      if (capture_now) capture_now_cnt <= capture_now_cnt + 1;
   end

   // Head word moves on the falling edge after a pop
   always @(negedge cwusb_clk) begin
      if (pop_seen) begin
         if (fifo_q.size() == 0) begin
            errors++;
            $display("%0t: fifo_read popped the FIFO model while it was empty", $time);
         end else begin
            void'(fifo_q.pop_front());
         end
      end
      fifo_empty = (fifo_q.size() == 0);
      fifo_data  = fifo_empty ? '0 : fifo_q[0];
   end

   ////////////////////////////////////////
   // Bus and sequence tasks
   ////////////////////////////////////////

   task automatic abort_run(input string why);
      $display("Timeout: %s", why);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   task automatic bus_write(input logic vld, input logic [7:0] adr,
                            input logic [bytecnt_w-1:0] cnt, input logic [7:0] dat);
      @(negedge cwusb_clk);
      reg_addrvalid = vld;
      reg_address   = adr;
      reg_bytecnt   = cnt;
      write_data    = dat;
      reg_write     = 1'b1;
      @(posedge cwusb_clk);
      check_bit(selected, vld && (adr[7:6] == main_sel), "selected on write");
      @(negedge cwusb_clk);
      reg_write     = 1'b0;
      reg_addrvalid = 1'b0;
      model_write(vld, adr, cnt, dat);
   endtask

   task automatic bus_read(input logic vld, input logic [7:0] adr,
                           input logic [bytecnt_w-1:0] cnt);
      @(negedge cwusb_clk);
      reg_addrvalid = vld;
      reg_address   = adr;
      reg_bytecnt   = cnt;
      reg_read      = 1'b1;
      @(posedge cwusb_clk);
      check_bit(selected, vld && (adr[7:6] == main_sel), "selected on read");
      @(negedge cwusb_clk);
      reg_read      = 1'b0;
      reg_addrvalid = 1'b0;
   endtask

   task automatic push_words(input int n);
      int k;
      int t;
      for (k = 0; k < n; k++) begin
         fifo_q.push_back(fifo_w'($random(seed)));
      end
      t = 0;
      while (fifo_empty !== 1'b0) begin
         @(negedge cwusb_clk);
         t++;
         if (t > 8) abort_run("FIFO model never showed data after a push");
      end
      // Let the registered empty flag follow
      repeat (2) @(negedge cwusb_clk);
   endtask

   task automatic fifo_group(input int g);
      int pops_before;
      int k;
      logic expect_pop;
      @(negedge cwusb_clk);
      fifo_status = fifo_status_w'($random(seed));
      expect_pop = (fifo_q.size() > 0);
      if (expect_pop) begin
         m_word  = fifo_q[0];
         m_empty = 1'b0;
      end else begin
         m_empty = 1'b1;
      end
      pops_before = fifo_read_cnt;
      for (k = 0; k < 4; k++) begin
         bus_read(1'b1, {main_sel, FIFO_RD}, bytecnt_w'(4 * (g % 32) + k));
      end
      check_count(fifo_read_cnt - pops_before, expect_pop ? 1 : 0, "fifo_read per group");
   endtask

   task automatic finish_test(input string name);
      // One idle cycle so the last read has been compared
      @(negedge cwusb_clk);
      tests++;
      if (errors == err_mark) begin
         $display("Test %0d %s: ok", tests, name);
      end else begin
         $display("Test %0d %s: %0d errors", tests, name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      reg_address = 8'd0;
      reg_bytecnt = '0;
      write_data = 8'd0;
      reg_read = 1'b0;
      reg_write = 1'b0;
      reg_addrvalid = 1'b0;
      fifo_data = '0;
      fifo_status = '0;
      fifo_empty = 1'b1;
      capture_started = 1'b0;
      flushing = 1'b0;
      m_fe = FE_USB;
      m_len = '0;
      m_cw = 1'b0;
      m_cwt = 1'b0;
      m_arm = 1'b0;
      m_word = '0;
      m_empty = 1'b0;

      timeout = 0;
      while (fpga_reset !== 1'b0) begin
         @(negedge cwusb_clk);
         timeout++;
         if (timeout > 20) abort_run("fpga_reset never released");
      end
      @(negedge cwusb_clk);

      // Reset values
      check_bit(fifo_read, 1'b0, "fifo_read");
      check_bit(arm, 1'b0, "arm");
      check_bit(reg_arm, 1'b0, "reg_arm");
      check_bit(arm_pulse, 1'b0, "arm_pulse");
      check_bit(capture_now, 1'b0, "capture_now");
      check_byte(read_data, 8'd0, "read_data");
      check_config();
      bus_read(1'b1, {main_sel, FE_SELECT}, 0);
      bus_read(1'b1, {main_sel, ARM}, 0);
      for (i = 0; i < 3; i++) begin
         bus_read(1'b1, {main_sel, CAPTURE_LEN}, bytecnt_w'(i));
      end
      bus_read(1'b1, {main_sel, COUNT_WRITES}, 0);
      bus_read(1'b1, {main_sel, CAPTURE_WHILE_TRIG}, 0);
      bus_read(1'b1, {main_sel, FIFO_STAT}, 0);
      finish_test("reset values");

      // Random config writes, foreign window and unmapped accesses
      for (i = 0; i < 40; i++) begin
         kind = $unsigned($random(seed)) % 7;
         data = $random(seed);
         bc = '0;
         valid = 1'b1;
         case (kind)
            0: begin
               address = {main_sel, FE_SELECT};
               data[1:0] = 2'($unsigned($random(seed)) % 3);
            end
            1: begin
               address = {main_sel, CAPTURE_LEN};
               bc = bytecnt_w'($unsigned($random(seed)) % 4);
            end
            2: address = {main_sel, COUNT_WRITES};
            3: address = {main_sel, CAPTURE_WHILE_TRIG};
            4: begin
               address[7:6] = 2'd1 + 2'($unsigned($random(seed)) % 3);
               address[5:0] = 6'($unsigned($random(seed)) % 8);
            end
            5: address = {main_sel, 6'(8 + $unsigned($random(seed)) % 56)};
            default: begin
               valid = 1'b0;
               address = {main_sel, CAPTURE_LEN};
               bc = bytecnt_w'($unsigned($random(seed)) % 3);
            end
         endcase
         bus_write(valid, address, bc, data);
         check_config();
         bus_read(valid, address, bc);
      end
      for (i = 0; i < 4; i++) begin
         bus_read(1'b1, {main_sel, CAPTURE_LEN}, bytecnt_w'(i));
      end
      finish_test("config write and readback");

      // Arm request, flushing and capture start
      count_before = arm_pulse_cnt;
      bus_write(1'b1, {main_sel, ARM}, 0, 8'h01);
      timeout = 0;
      while (arm !== 1'b1) begin
         @(negedge cwusb_clk);
         timeout++;
         if (timeout > 10) abort_run("arm never rose after the ARM write");
      end
      check_count(arm_pulse_cnt - count_before, 1, "arm_pulse cycles");
      check_bit(reg_arm, 1'b1, "reg_arm after ARM write");
      bus_read(1'b1, {main_sel, ARM}, 0);
      @(negedge cwusb_clk);
      flushing = 1'b1;
      @(negedge cwusb_clk);
      check_bit(arm, 1'b0, "arm while flushing");
      check_bit(reg_arm, 1'b1, "reg_arm while flushing");
      flushing = 1'b0;
      @(negedge cwusb_clk);
      check_bit(arm, 1'b1, "arm after flushing");
      capture_started = 1'b1;
      @(negedge cwusb_clk);
      capture_started = 1'b0;
      m_arm = 1'b0;
      check_bit(reg_arm, 1'b0, "reg_arm after capture start");
      check_bit(arm, 1'b0, "arm after capture start");
      bus_read(1'b1, {main_sel, ARM}, 0);
      check_count(arm_pulse_cnt - count_before, 1, "arm_pulse cycles in total");
      finish_test("arm control");

      // Capture-now pulse, 1 cycle after the write edge
      count_before = capture_now_cnt;
      bus_write(1'b1, {main_sel, ARM}, 0, 8'h02);
      check_bit(capture_now, 1'b1, "capture_now after write");
      @(negedge cwusb_clk);
      check_bit(capture_now, 1'b0, "capture_now one cycle later");
      repeat (2) @(negedge cwusb_clk);
      check_count(capture_now_cnt - count_before, 1, "capture_now cycles");
      check_bit(reg_arm, 1'b0, "reg_arm after capture-now write");
      finish_test("capture now");

      // Four-byte groups with data in the FIFO
      push_words(6);
      for (i = 0; i < 6; i++) begin
         fifo_group(i);
      end
      finish_test("FIFO group reads");

      // Empty FIFO gives the marker, then real data again
      fifo_group(6);
      push_words(2);
      fifo_group(7);
      fifo_group(8);
      fifo_group(9);
      finish_test("empty stream marker");

      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* vlog.f */
hdl/main_reg_pkg.sv
hdl/reg_decode.sv
hdl/config_regs.sv
hdl/capture_ctrl.sv
hdl/read_path.sv
hdl/reg_main.sv
test/tb_clock_gen.sv
test/reg_main_sva.sv
test/reg_main_tb.sv
